/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module permu_tb -Mdir build -o permu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./build/permu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" sim.log; then
   exit 0
fi
exit 1

/* source/permu_gather_unit.sv */
// Operand collection and 16-bit element gather between lane and element layout
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_gather_unit import permu_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   // Issued instruction
   input  logic       issue_valid_i,
   input  pe_req_t    issue_req_i,
   // Operand beats from the lanes
   input  logic       operand_valid_i,
   input  logic       sel_idx_val_i,
   input  lane_beat_t operand_i,
   output logic       operand_ready_o,
   // Result handoff
   input  logic       stage_free_i,
   output logic       fire_o,
   output result_t    result_o
);

   localparam int unsigned NumLanes  = `PERMU_NUM_LANES;
   localparam int unsigned ElemsLane = `PERMU_ELEN / `PERMU_EW;
   localparam int unsigned NumElems  = NumLanes * ElemsLane;
   localparam int unsigned IdxW      = $clog2(NumElems);
   localparam int unsigned StrideLog = $clog2(`PERMU_VREG_STRIDE);

   typedef elem_t [NumElems-1:0] elem_vec_t;

   // Incoming beat in element order
   elem_vec_t  operand_elems;
   elem_vec_t  table_q;
   elem_vec_t  idx_q;
   logic       table_full_q;
   logic       idx_full_q;
   elem_vec_t  gathered;
   lane_beat_t shuffled;
   logic       slot_free;
   logic       capture;

   ////////////////////////////////////////////////////////////
   // Operand slots
   ////////////////////////////////////////////////////////////

   assign slot_free       = sel_idx_val_i ? !idx_full_q : !table_full_q;
   assign operand_ready_o = issue_valid_i && slot_free;
   assign capture         = operand_valid_i && operand_ready_o;

   // Element e lives in lane e mod 4, slot e div 4
   always_comb begin
      for (int e = 0; e < NumElems; e++) begin
         operand_elems[e] = operand_i[e % NumLanes][`PERMU_EW*(e / NumLanes) +: `PERMU_EW];
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         table_full_q <= 1'b0;
         idx_full_q   <= 1'b0;
      end else if (fire_o) begin
         table_full_q <= 1'b0;
         idx_full_q   <= 1'b0;
      end else if (capture) begin
         if (sel_idx_val_i) begin
            idx_full_q <= 1'b1;
         end else begin
            table_full_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture && !sel_idx_val_i) begin
         table_q <= operand_elems;
      end
      if (capture && sel_idx_val_i) begin
         idx_q <= operand_elems;
      end
   end

   ////////////////////////////////////////////////////////////
   // Gather and shuffle back
   ////////////////////////////////////////////////////////////

   always_comb begin
      // Index taken modulo the element count
      for (int i = 0; i < NumElems; i++) begin
         gathered[i] = table_q[idx_q[i][IdxW-1:0]];
      end
      for (int l = 0; l < NumLanes; l++) begin
         for (int s = 0; s < ElemsLane; s++) begin
            shuffled[l][`PERMU_EW*s +: `PERMU_EW] = gathered[s*NumLanes + l];
         end
      end
   end

   // Waits for a free result stage with both slots loaded
   assign fire_o = issue_valid_i && table_full_q && idx_full_q && stage_free_i;

   always_comb begin
      result_o.id    = issue_req_i.id;
      result_o.addr  = vaddr_t'(issue_req_i.vd) << StrideLog;
      result_o.wdata = shuffled;
   end

endmodule

`default_nettype wire

/* source/permu_insn_queue.sv */
// Instruction queue of the permutation unit with accept, issue and commit phases
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_insn_queue import permu_pkg::*; (
   input  logic                       clk_i,
   input  logic                       rst_ni,
   // Main sequencer
   input  pe_req_t                    pe_req_i,
   input  logic                       pe_req_valid_i,
   input  logic [`PERMU_NR_VINSN-1:0] pe_vinsn_running_i,
   output logic                       pe_req_ready_o,
   // Towards the gather unit
   output logic                       issue_valid_o,
   output pe_req_t                    issue_req_o,
   input  logic                       fire_i,
   // From the result stage
   input  logic                       commit_i,
   output pe_resp_t                   pe_resp_o
);

   localparam int unsigned Depth = `PERMU_QUEUE_DEPTH;
   localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
   localparam int unsigned CntW  = $clog2(Depth + 1);

   typedef logic [PntW-1:0] pnt_t;
   typedef logic [CntW-1:0] cnt_t;

   pe_req_t [Depth-1:0]        queue_q;
   pnt_t                       accept_pnt_q;
   pnt_t                       issue_pnt_q;
   pnt_t                       commit_pnt_q;
   // Waiting for operands, and waiting for all lane grants
   cnt_t                       issue_cnt_q;
   cnt_t                       commit_cnt_q;
   logic [`PERMU_NR_VINSN-1:0] running_q;
   logic [`PERMU_NR_VINSN-1:0] running_d;
   pe_resp_t                   resp_d;
   logic                       queue_full;
   logic                       accept;

   function automatic pnt_t next_pnt(pnt_t pnt);
      return (pnt == pnt_t'(Depth - 1)) ? '0 : pnt + 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////
   // Accept and issue
   ////////////////////////////////////////////////////////////

   // An entry is held until its commit
   assign queue_full     = (commit_cnt_q == cnt_t'(Depth));
   assign pe_req_ready_o = !queue_full;

   // Requests for other units are left untouched
   assign accept = pe_req_valid_i && !queue_full && !running_q[pe_req_i.id] &&
                   (pe_req_i.vfu == VFU_PERM);

   assign issue_valid_o = (issue_cnt_q != '0);
   assign issue_req_o   = queue_q[issue_pnt_q];

   always_comb begin
      // Bits drop once the sequencer lets go of the id
      running_d = running_q & pe_vinsn_running_i;
      if (accept) begin
         running_d[pe_req_i.id] = 1'b1;
      end

      // Oldest entry is the one in the result stage
      resp_d = '0;
      if (commit_i) begin
         resp_d.vinsn_done[queue_q[commit_pnt_q].id] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // State
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         accept_pnt_q <= '0;
         issue_pnt_q  <= '0;
         commit_pnt_q <= '0;
         issue_cnt_q  <= '0;
         commit_cnt_q <= '0;
         running_q    <= '0;
         pe_resp_o    <= '0;
      end else begin
         if (accept) begin
            accept_pnt_q <= next_pnt(accept_pnt_q);
         end
         if (fire_i) begin
            issue_pnt_q <= next_pnt(issue_pnt_q);
         end
         if (commit_i) begin
            commit_pnt_q <= next_pnt(commit_pnt_q);
         end
         issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(fire_i);
         commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_i);
         running_q    <= running_d;
         // Done pulse lasts one cycle
         pe_resp_o    <= resp_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         queue_q[accept_pnt_q] <= pe_req_i;
      end
   end

endmodule

`default_nettype wire

/* source/permu_macros.svh */
// Size parameters of the vector permutation unit
`ifndef PERMU_MACROS_SVH
`define PERMU_MACROS_SVH

////////////////////////////////////////////////////////////
// Lane geometry
////////////////////////////////////////////////////////////

// Lanes fed by the unit, one word each per beat
`define PERMU_NUM_LANES 4

// Width of one lane word
`define PERMU_ELEN 64

// Gather element width
`define PERMU_EW 16

////////////////////////////////////////////////////////////
// Sequencer side
////////////////////////////////////////////////////////////

`define PERMU_QUEUE_DEPTH 2

// Identifiers the main sequencer hands out
`define PERMU_NR_VINSN 8

// Register file words per vector register
`define PERMU_VREG_STRIDE 4

`endif

/* source/permu_pkg.sv */
// Types shared by the vector permutation unit and its environment
`default_nettype none
`include "permu_macros.svh"

package permu_pkg;

   // Architectural vector registers
   localparam int unsigned NrVRegs = 32;

   // One lane word
   typedef logic [`PERMU_ELEN-1:0] elen_t;

   // One gather element
   typedef logic [`PERMU_EW-1:0] elem_t;

   // Instruction identifier handed out by the sequencer
   typedef logic [$clog2(`PERMU_NR_VINSN)-1:0] vid_t;

   typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

   // Register file word address, same in every lane
   typedef logic [$clog2(NrVRegs*`PERMU_VREG_STRIDE)-1:0] vaddr_t;

   // A beat in lane layout, word l goes to lane l
   typedef elen_t [`PERMU_NUM_LANES-1:0] lane_beat_t;

   // Target unit of a sequencer request
   typedef enum logic [0:0] {
      VFU_PERM  = 1'b0,
      VFU_OTHER = 1'b1
   } vfu_e;

   typedef struct packed {
      vid_t  id;
      vreg_t vd;
      vfu_e  vfu;
   } pe_req_t;

   // One done bit per identifier
   typedef struct packed {
      logic [`PERMU_NR_VINSN-1:0] vinsn_done;
   } pe_resp_t;

   // Result beat with its destination
   typedef struct packed {
      vid_t       id;
      vaddr_t     addr;
      lane_beat_t wdata;
   } result_t;

endpackage

`default_nettype wire

/* source/permu_result_stage.sv */
// Result holding stage with per-lane write requests towards the register file
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_result_stage import permu_pkg::*; (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic                              load_i,
   input  result_t                           result_i,
   // Lane write ports
   output logic   [`PERMU_NUM_LANES-1:0]     permu_result_req_o,
   output vid_t   [`PERMU_NUM_LANES-1:0]     permu_result_id_o,
   output vaddr_t [`PERMU_NUM_LANES-1:0]     permu_result_addr_o,
   output elen_t  [`PERMU_NUM_LANES-1:0]     permu_result_wdata_o,
   input  logic   [`PERMU_NUM_LANES-1:0]     permu_result_gnt_i,
   // Status
   output logic                              stage_free_o,
   output logic                              commit_o
);

   logic [`PERMU_NUM_LANES-1:0] pending_q;
   logic [`PERMU_NUM_LANES-1:0] remaining;
   result_t                     result_q;

   // Lanes still waiting after this cycle's grants
   assign remaining    = pending_q & ~permu_result_gnt_i;
   assign stage_free_o = (pending_q == '0);
   assign commit_o     = !stage_free_o && (remaining == '0);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pending_q <= '0;
      end else if (load_i) begin
         pending_q <= '1;
      end else begin
         pending_q <= remaining;
      end
   end

   // Held stable until every lane is granted
   always_ff @(posedge clk_i) begin
      if (load_i) begin
         result_q <= result_i;
      end
   end

   always_comb begin
      for (int l = 0; l < `PERMU_NUM_LANES; l++) begin
         permu_result_req_o[l]   = pending_q[l];
         permu_result_id_o[l]    = result_q.id;
         permu_result_addr_o[l]  = result_q.addr;
         permu_result_wdata_o[l] = result_q.wdata[l];
      end
   end

endmodule

`default_nettype wire

/* source/permu_top.sv */
// Vector permutation unit top level with queue, gather unit and result stage
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_top import permu_pkg::*; (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   // Main sequencer
   input  pe_req_t                        pe_req_i,
   input  logic                           pe_req_valid_i,
   input  logic   [`PERMU_NR_VINSN-1:0]   pe_vinsn_running_i,
   output logic                           pe_req_ready_o,
   output pe_resp_t                       pe_resp_o,
   // Operands from the lanes
   input  logic                           operand_valid_i,
   input  logic                           sel_idx_val_i,
   input  lane_beat_t                     operand_i,
   output logic                           operand_ready_o,
   // Results to the lanes
   output logic   [`PERMU_NUM_LANES-1:0]  permu_result_req_o,
   output vid_t   [`PERMU_NUM_LANES-1:0]  permu_result_id_o,
   output vaddr_t [`PERMU_NUM_LANES-1:0]  permu_result_addr_o,
   output elen_t  [`PERMU_NUM_LANES-1:0]  permu_result_wdata_o,
   input  logic   [`PERMU_NUM_LANES-1:0]  permu_result_gnt_i
);

   logic    issue_valid;
   pe_req_t issue_req;
   logic    fire;
   logic    commit;
   logic    stage_free;
   result_t result;

   permu_insn_queue u_insn_queue (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .pe_req_i           (pe_req_i),
      .pe_req_valid_i     (pe_req_valid_i),
      .pe_vinsn_running_i (pe_vinsn_running_i),
      .pe_req_ready_o     (pe_req_ready_o),
      .issue_valid_o      (issue_valid),
      .issue_req_o        (issue_req),
      .fire_i             (fire),
      .commit_i           (commit),
      .pe_resp_o          (pe_resp_o)
   );

   permu_gather_unit u_gather_unit (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .issue_valid_i   (issue_valid),
      .issue_req_i     (issue_req),
      .operand_valid_i (operand_valid_i),
      .sel_idx_val_i   (sel_idx_val_i),
      .operand_i       (operand_i),
      .operand_ready_o (operand_ready_o),
      .stage_free_i    (stage_free),
      .fire_o          (fire),
      .result_o        (result)
   );

   permu_result_stage u_result_stage (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .load_i               (fire),
      .result_i             (result),
      .permu_result_req_o   (permu_result_req_o),
      .permu_result_id_o    (permu_result_id_o),
      .permu_result_addr_o  (permu_result_addr_o),
      .permu_result_wdata_o (permu_result_wdata_o),
      .permu_result_gnt_i   (permu_result_gnt_i),
      .stage_free_o         (stage_free),
      .commit_o             (commit)
   );

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/permu_pkg.sv
source/permu_insn_queue.sv
source/permu_gather_unit.sv
source/permu_result_stage.sv
source/permu_top.sv
tests/permu_checker.sv
tests/permu_tb.sv

/* tests/permu_checker.sv */
// Bound protocol checks on the permutation unit write ports, operand slots and done response
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_checker import permu_pkg::*; (
   input logic                                  clk_i,
   input logic                                  rst_ni,
   input logic   [`PERMU_NUM_LANES-1:0]         req_i,
   input logic   [`PERMU_NUM_LANES-1:0]         gnt_i,
   input vid_t   [`PERMU_NUM_LANES-1:0]         id_i,
   input vaddr_t [`PERMU_NUM_LANES-1:0]         addr_i,
   input elen_t  [`PERMU_NUM_LANES-1:0]         wdata_i,
   input logic                                  operand_ready_i,
   input logic                                  table_full_i,
   input logic                                  idx_full_i,
   input pe_resp_t                              pe_resp_i
);

   ////////////////////////////////////////////////////////////
   // Lane write ports
   ////////////////////////////////////////////////////////////

   for (genvar l = 0; l < `PERMU_NUM_LANES; l++) begin : g_lane
      // Ungranted request keeps its payload
      a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
         req_i[l] && !gnt_i[l] |=> req_i[l] && $stable(id_i[l]) && $stable(addr_i[l]) &&
                                   $stable(wdata_i[l]))
         else $error("Lane %0d dropped or changed its write request before the grant", l);
   end

   ////////////////////////////////////////////////////////////
   // Operand slots and done response
   ////////////////////////////////////////////////////////////

   a_slots_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      table_full_i && idx_full_i |-> !operand_ready_i)
      else $error("Operand ready while both operand slots are full");

   a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_resp_i != '0 |=> pe_resp_i == '0)
      else $error("Done response held for more than one cycle");

endmodule

bind permu_top permu_checker u_checker (
   .clk_i           (clk_i),
   .rst_ni          (rst_ni),
   .req_i           (permu_result_req_o),
   .gnt_i           (permu_result_gnt_i),
   .id_i            (permu_result_id_o),
   .addr_i          (permu_result_addr_o),
   .wdata_i         (permu_result_wdata_o),
   .operand_ready_i (operand_ready_o),
   .table_full_i    (u_gather_unit.table_full_q),
   .idx_full_i      (u_gather_unit.idx_full_q),
   .pe_resp_i       (pe_resp_o)
);

`default_nettype wire

/* tests/permu_tb.sv */
// Testbench of the vector permutation unit with random gathers against a reference model
`default_nettype none
`timescale 1ns/1ns
`include "permu_macros.svh"

module permu_tb import permu_pkg::*; ();

   localparam int unsigned NumLanes = `PERMU_NUM_LANES;
   localparam int unsigned NumElems = NumLanes * (`PERMU_ELEN / `PERMU_EW);
   localparam int unsigned Timeout  = 200;
   localparam logic [31:0] Taps     = 32'h80200003;

   logic                       clk_i;
   logic                       rst_ni;
   pe_req_t                    pe_req_i;
   logic                       pe_req_valid_i;
   logic [`PERMU_NR_VINSN-1:0] pe_vinsn_running_i;
   logic                       pe_req_ready_o;
   pe_resp_t                   pe_resp_o;
   logic                       operand_valid_i;
   logic                       sel_idx_val_i;
   lane_beat_t                 operand_i;
   logic                       operand_ready_o;
   logic   [NumLanes-1:0]      permu_result_req_o;
   vid_t   [NumLanes-1:0]      permu_result_id_o;
   vaddr_t [NumLanes-1:0]      permu_result_addr_o;
   elen_t  [NumLanes-1:0]      permu_result_wdata_o;
   logic   [NumLanes-1:0]      permu_result_gnt_i;

   logic [31:0] lfsr_state = 32'h75d644ee;
   int unsigned value_errors = 0;
   int unsigned proto_errors = 0;
   int unsigned timeouts = 0;
   // Expected results in commit order
   result_t     exp_q[$];
   logic        hold_grants = 1'b0;
   logic        done_due = 1'b0;
   vid_t        done_id = '0;
   vid_t        next_id = '0;

   permu_top u_permu_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////
   // Random numbers, model and compare tasks
   ////////////////////////////////////////////////////////////

   function automatic logic [63:0] random_bits(input int unsigned n);
      logic [63:0] v;
      v = '0;
      for (int unsigned b = 0; b < n; b++) begin
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? Taps : 32'h0);
         v[b] = lfsr_state[0];
      end
      return v;
   endfunction

   // Element e sits in lane e mod 4, slot e div 4
   function automatic lane_beat_t model_gather(input lane_beat_t tbl, input lane_beat_t idx);
      elem_t      tbl_el [NumElems];
      elem_t      idx_el [NumElems];
      lane_beat_t res;
      for (int e = 0; e < NumElems; e++) begin
         tbl_el[e] = tbl[e % NumLanes][`PERMU_EW*(e / NumLanes) +: `PERMU_EW];
         idx_el[e] = idx[e % NumLanes][`PERMU_EW*(e / NumLanes) +: `PERMU_EW];
      end
      for (int e = 0; e < NumElems; e++) begin
         res[e % NumLanes][`PERMU_EW*(e / NumLanes) +: `PERMU_EW] = tbl_el[idx_el[e] % NumElems];
      end
      return res;
   endfunction

   task automatic check_beat(input lane_beat_t got, input lane_beat_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input vaddr_t got, input vaddr_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_id(input vid_t got, input vid_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input pe_resp_t got, input pe_resp_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d wrong values, %0d protocol errors, %0d timeouts",
               value_errors, proto_errors, timeouts);
      if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   endtask

   task automatic timed_out(input string what);
      timeouts++;
      $display("Timeout at %0t while waiting for %s", $time, what);
      finish_run();
   endtask

   ////////////////////////////////////////////////////////////
   // Sequencer and operand drivers
   ////////////////////////////////////////////////////////////

   task automatic to_drive_point();
      @(posedge clk_i);
      #1;
   endtask

   function automatic vid_t take_id();
      vid_t id;
      id = next_id;
      next_id = next_id + 1'b1;
      return id;
   endfunction

   function automatic vreg_t random_vd();
      return vreg_t'(random_bits(5));
   endfunction

   task automatic send_req(input vid_t id, input vreg_t vd);
      int unsigned n;
      pe_req_i.id            = id;
      pe_req_i.vd            = vd;
      pe_req_i.vfu           = VFU_PERM;
      pe_req_valid_i         = 1'b1;
      pe_vinsn_running_i[id] = 1'b1;
      n = 0;
      @(negedge clk_i);
      while (!pe_req_ready_o && n < Timeout) begin
         n++;
         @(negedge clk_i);
      end
      if (n >= Timeout) timed_out("the request to be accepted");
      to_drive_point();
      pe_req_valid_i = 1'b0;
   endtask

   // Held for a few cycles, then withdrawn
   task automatic present_refused(input vid_t id, input vreg_t vd, input vfu_e vfu);
      pe_req_i.id    = id;
      pe_req_i.vd    = vd;
      pe_req_i.vfu   = vfu;
      pe_req_valid_i = 1'b1;
      repeat (3) to_drive_point();
      pe_req_valid_i = 1'b0;
   endtask

   task automatic send_operand(input lane_beat_t beat, input logic sel);
      int unsigned n;
      operand_i       = beat;
      sel_idx_val_i   = sel;
      operand_valid_i = 1'b1;
      n = 0;
      @(negedge clk_i);
      while (!operand_ready_o && n < Timeout) begin
         n++;
         @(negedge clk_i);
      end
      if (n >= Timeout) timed_out("operand ready");
      to_drive_point();
      operand_valid_i = 1'b0;
   endtask

   task automatic feed_operands(input vid_t id, input vreg_t vd);
      lane_beat_t  tbl;
      lane_beat_t  idx;
      result_t     exp;
      logic [63:0] order;
      for (int l = 0; l < NumLanes; l++) begin
         tbl[l] = random_bits(64);
         idx[l] = random_bits(64);
      end
      exp.id    = id;
      exp.addr  = vaddr_t'(vd * `PERMU_VREG_STRIDE);
      exp.wdata = model_gather(tbl, idx);
      exp_q.push_back(exp);
      order = random_bits(1);
      // Table and indices may come in either order
      if (order[0]) begin
         send_operand(idx, 1'b1);
         send_operand(tbl, 1'b0);
      end else begin
         send_operand(tbl, 1'b0);
         send_operand(idx, 1'b1);
      end
   endtask

   task automatic run_insn();
      vid_t  id;
      vreg_t vd;
      id = take_id();
      vd = random_vd();
      send_req(id, vd);
      feed_operands(id, vd);
   endtask

   task automatic wait_drain();
      int unsigned n;
      n = 0;
      while ((exp_q.size() != 0 || done_due) && n < Timeout) begin
         n++;
         to_drive_point();
      end
      if (n >= Timeout) timed_out("all results to be written");
      repeat (2) to_drive_point();
   endtask

   task automatic expect_no_issue();
      repeat (4) begin
         @(negedge clk_i);
         check_flag(operand_ready_o, 1'b0, "operand ready with nothing issued");
      end
      to_drive_point();
   endtask

   ////////////////////////////////////////////////////////////
   // Lane write responder with random grant delays
   ////////////////////////////////////////////////////////////

   initial begin : responder
      logic [NumLanes-1:0] taken;
      logic [NumLanes-1:0] gnt_next;
      int unsigned         delay [NumLanes];
      lane_beat_t          got;
      pe_resp_t            exp_resp;
      logic                release_valid;
      vid_t                release_id;
      logic [63:0]         r;
      taken = '0;
      got   = '0;
      release_id = '0;
      for (int l = 0; l < NumLanes; l++) delay[l] = 0;
      forever begin
         @(negedge clk_i);
         exp_resp      = '0;
         release_valid = 1'b0;
         if (done_due) begin
            exp_resp.vinsn_done[done_id] = 1'b1;
            release_valid = 1'b1;
            release_id    = done_id;
            done_due      = 1'b0;
         end
         check_resp(pe_resp_o, exp_resp, "done response");
         gnt_next = '0;
         for (int l = 0; l < NumLanes; l++) begin
            if (permu_result_req_o[l] && exp_q.size() == 0) begin
               proto_errors++;
               $display("Lane %0d requests a write with no result expected at %0t", l, $time);
            end else if (permu_result_req_o[l] && taken[l]) begin
               proto_errors++;
               $display("Lane %0d requests the same result again at %0t", l, $time);
            end else if (permu_result_req_o[l] && permu_result_gnt_i[l]) begin
               taken[l] = 1'b1;
               got[l]   = permu_result_wdata_o[l];
               check_id(permu_result_id_o[l], exp_q[0].id, $sformatf("lane %0d id", l));
               check_addr(permu_result_addr_o[l], exp_q[0].addr,
                          $sformatf("lane %0d address", l));
            end else if (permu_result_req_o[l] && !hold_grants) begin
               if (delay[l] == 0) gnt_next[l] = 1'b1;
               else delay[l]--;
            end
         end
         // All lanes written, so the done bit is due next cycle
         if (taken == '1) begin
            check_beat(got, exp_q[0].wdata, "write data");
            done_due = 1'b1;
            done_id  = exp_q[0].id;
            void'(exp_q.pop_front());
            taken = '0;
            for (int l = 0; l < NumLanes; l++) begin
               r = random_bits(2);
               delay[l] = int'(r[1:0]);
            end
         end
         to_drive_point();
         permu_result_gnt_i = gnt_next;
         if (release_valid) pe_vinsn_running_i[release_id] = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      vid_t  a_id;
      vid_t  b_id;
      vreg_t a_vd;
      vreg_t b_vd;
      rst_ni             = 1'b0;
      pe_req_i           = '0;
      pe_req_valid_i     = 1'b0;
      pe_vinsn_running_i = '0;
      operand_valid_i    = 1'b0;
      sel_idx_val_i      = 1'b0;
      operand_i          = '0;
      permu_result_gnt_i = '0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      // Idle state after reset
      @(negedge clk_i);
      check_flag(pe_req_ready_o, 1'b1, "request ready after reset");
      check_flag(operand_ready_o, 1'b0, "operand ready after reset");
      check_flag(|permu_result_req_o, 1'b0, "write request after reset");
      to_drive_point();

      // Random gathers with random grant delays
      repeat (12) run_insn();
      wait_drain();

      // Full queue refuses a third request
      a_id = take_id();
      a_vd = random_vd();
      b_id = take_id();
      b_vd = random_vd();
      send_req(a_id, a_vd);
      send_req(b_id, b_vd);
      @(negedge clk_i);
      check_flag(pe_req_ready_o, 1'b0, "request ready with a full queue");
      to_drive_point();
      present_refused(next_id, random_vd(), VFU_PERM);
      feed_operands(a_id, a_vd);
      feed_operands(b_id, b_vd);
      wait_drain();
      expect_no_issue();

      // Requests for another unit are left alone
      present_refused(next_id, random_vd(), VFU_OTHER);
      expect_no_issue();

      // Request with an id still running
      a_id = take_id();
      a_vd = random_vd();
      send_req(a_id, a_vd);
      present_refused(a_id, random_vd(), VFU_PERM);
      feed_operands(a_id, a_vd);
      wait_drain();
      expect_no_issue();

      // Second instruction collected while the first waits for grants
      hold_grants = 1'b1;
      run_insn();
      run_insn();
      @(negedge clk_i);
      check_flag(operand_ready_o, 1'b0, "operand ready with both slots full");
      check_flag(&permu_result_req_o, 1'b1, "write requests of the held result");
      repeat (5) to_drive_point();
      hold_grants = 1'b0;
      wait_drain();

      finish_run();
   end

endmodule

`default_nettype wire
